// File: all.f
logic/ps2_pkg.sv
logic/ps2_line_filter.sv
logic/ps2_frame_shifter.sv
logic/ps2_link_fsm.sv
logic/ps2_host_port.sv
logic/ps2_host.sv
test/ps2_host_props.sv
test/ps2_host_tb.sv

// File: logic/ps2_frame_shifter.sv
`timescale 1ns/1ps

// shared frame register for both directions plus bit counter
module ps2_frame_shifter (
  input  logic           clk,
  input  logic           rst,
  input  logic           load,       // copy tx byte into frame
  input  logic           shift,      // one bit in from data_s, one out at bit 0
  input  logic           clear,      // zero the bit count
  input  ps2_pkg::byte_t tx_data,
  input  logic           data_s,     // filtered data line
  output ps2_pkg::count_t bit_count,
  output logic           tx_bit,     // bit currently on the wire when sending
  output ps2_pkg::byte_t rx_byte,
  output logic           parity_ok
);

  ps2_pkg::frame_t frame;  // {stop, parity, d7..d0, start}

  ////////////////////
  // frame register
  ////////////////////
  always_ff @(posedge clk) begin
    if (load) begin
      frame <= {1'b1,                            // stop
                ps2_pkg::odd_parity(tx_data),    // parity
                tx_data,
                1'b0};                           // start
    end else if (shift) begin
      // new bit enters at the top, lsb leaves first
      frame <= {data_s, frame[ps2_pkg::FRAME_BITS-1:1]};
    end
  end

  ////////////////////
  // bit counter
  ////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_count <= '0;
    end else if (clear) begin
      bit_count <= '0;
    end else if (shift) begin
      bit_count <= bit_count + 4'd1;  // counts shifts in either direction
    end
  end

  assign tx_bit  = frame[0];
  assign rx_byte = frame[ps2_pkg::DATA_W:1];  // data sits between start and parity

  // after 11 shifts the received parity bit lands at index 9
  assign parity_ok = (ps2_pkg::odd_parity(rx_byte) == frame[ps2_pkg::DATA_W+1]);

endmodule

// File: logic/ps2_host.sv
`timescale 1ns/1ps

// host-side ps/2 link controller
module ps2_host #(
  parameter int DEBOUNCE_CYCLES     = 15,
  parameter int HOLD_CLK_CYCLES     = 10000,
  parameter int HOLD_DATA_CYCLES    = 2000,
  parameter int RELEASE_WAIT_CYCLES = 63
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           ps2_clk_in,   // sensed clock line
  input  logic           ps2_data_in,  // sensed data line
  input  logic           tx_valid,
  input  ps2_pkg::byte_t tx_data,
  output ps2_pkg::byte_t rx_data,
  output logic           rx_valid,
  output logic           busy,
  output logic           err,
  output logic           ps2_clk_low,
  output logic           ps2_data_low
);

  logic            clk_s, data_s;          // filtered lines
  logic            load, shift, clear;     // fsm -> shifter
  ps2_pkg::count_t bit_count;
  logic            tx_bit, parity_ok;
  ps2_pkg::byte_t  rx_byte;
  logic            rx_done, clk_low_next, data_low_next;

  ////////////////////
  // input side
  ////////////////////
  ps2_line_filter #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_clk_filter (
    .clk(clk), .rst(rst), .line_in(ps2_clk_in), .line_s(clk_s)
  );

  ps2_line_filter #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_data_filter (
    .clk(clk), .rst(rst), .line_in(ps2_data_in), .line_s(data_s)
  );

  ////////////////////
  // processing
  ////////////////////
  ps2_frame_shifter u_shifter (
    .clk(clk), .rst(rst), .load(load), .shift(shift), .clear(clear),
    .tx_data(tx_data), .data_s(data_s), .bit_count(bit_count),
    .tx_bit(tx_bit), .rx_byte(rx_byte), .parity_ok(parity_ok)
  );

  ps2_link_fsm #(
    .HOLD_CLK_CYCLES(HOLD_CLK_CYCLES),
    .HOLD_DATA_CYCLES(HOLD_DATA_CYCLES),
    .RELEASE_WAIT_CYCLES(RELEASE_WAIT_CYCLES)
  ) u_fsm (
    .clk(clk), .rst(rst), .clk_s(clk_s), .data_s(data_s), .tx_valid(tx_valid),
    .bit_count(bit_count), .tx_bit(tx_bit), .parity_ok(parity_ok),
    .load(load), .shift(shift), .clear(clear), .rx_done(rx_done),
    .clk_low_next(clk_low_next), .data_low_next(data_low_next),
    .busy(busy), .err(err)
  );

  ////////////////////
  // output side
  ////////////////////
  ps2_host_port u_port (
    .clk(clk), .rst(rst), .rx_done(rx_done), .clk_low_next(clk_low_next),
    .data_low_next(data_low_next), .rx_byte(rx_byte), .rx_data(rx_data),
    .rx_valid(rx_valid), .ps2_clk_low(ps2_clk_low), .ps2_data_low(ps2_data_low)
  );

endmodule

// File: logic/ps2_host_port.sv
`timescale 1ns/1ps

// registered outputs toward the client and the pads
module ps2_host_port (
  input  logic           clk,
  input  logic           rst,
  input  logic           rx_done,        // good frame, one cycle
  input  logic           clk_low_next,
  input  logic           data_low_next,
  input  ps2_pkg::byte_t rx_byte,
  output ps2_pkg::byte_t rx_data,
  output logic           rx_valid,
  output logic           ps2_clk_low,    // 1 pulls the clock line low
  output logic           ps2_data_low    // 1 pulls the data line low
);

  ////////////////////
  // client side
  ////////////////////
  // byte held until the next good frame
  always_ff @(posedge clk) begin
    if (rx_done) rx_data <= rx_byte;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) rx_valid <= 1'b0;
    else     rx_valid <= rx_done;  // lines up with rx_data update
  end

  ////////////////////
  // pad drives
  ////////////////////
  // flops so the open-drain enables never glitch
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ps2_clk_low  <= 1'b0;  // both lines released
      ps2_data_low <= 1'b0;
    end else begin
      ps2_clk_low  <= clk_low_next;
      ps2_data_low <= data_low_next;
    end
  end

endmodule

// File: logic/ps2_line_filter.sv
`timescale 1ns/1ps

// sync + debounce for one open-drain ps/2 line
module ps2_line_filter #(
  parameter int DEBOUNCE_CYCLES = 15
) (
  input  logic clk,
  input  logic rst,
  input  logic line_in,   // raw pin level
  output logic line_s     // filtered, clk domain
);

  // wide enough to reach DEBOUNCE_CYCLES, never zero width
  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 2);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES);

  logic             sample;  // intermediate copy of the raw line
  logic [CNT_W-1:0] cnt;     // cycles the sample has stayed equal to the pin

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sample <= 1'b1;   // bus idles high
      line_s <= 1'b1;
      cnt    <= '0;
    end else if (line_in != sample) begin
      // raw level moved, restart the stability window
      sample <= line_in;
      cnt    <= '0;
    end else if (cnt == CNT_LAST) begin
      line_s <= sample;  // stable long enough
    end else begin
      cnt <= cnt + CNT_W'(1);
    end
  end

  // a glitch shorter than the window only reloads sample,
  // line_s never sees it

endmodule

// File: logic/ps2_link_fsm.sv
`timescale 1ns/1ps

// receive / transmit sequencing for the ps/2 link
module ps2_link_fsm #(
  parameter int HOLD_CLK_CYCLES     = 10000,  // clock low before data goes low
  parameter int HOLD_DATA_CYCLES    = 2000,   // data low before clock release
  parameter int RELEASE_WAIT_CYCLES = 63      // settle time after clock release
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            clk_s,      // filtered device clock
  input  logic            data_s,     // filtered data line
  input  logic            tx_valid,
  input  ps2_pkg::count_t bit_count,
  input  logic            tx_bit,
  input  logic            parity_ok,
  output logic            load,
  output logic            shift,
  output logic            clear,
  output logic            rx_done,        // good frame ended
  output logic            clk_low_next,   // next clock-line pull
  output logic            data_low_next,  // next data-line pull
  output logic            busy,
  output logic            err
);

  // one delay counter serves all three waits
  localparam int MAX_DELAY =
    (HOLD_CLK_CYCLES > HOLD_DATA_CYCLES) ?
      ((HOLD_CLK_CYCLES > RELEASE_WAIT_CYCLES) ? HOLD_CLK_CYCLES : RELEASE_WAIT_CYCLES) :
      ((HOLD_DATA_CYCLES > RELEASE_WAIT_CYCLES) ? HOLD_DATA_CYCLES : RELEASE_WAIT_CYCLES);
  localparam int DELAY_W = $clog2(MAX_DELAY + 2);

  localparam logic [DELAY_W-1:0] HOLD_CLK_LAST  = DELAY_W'(HOLD_CLK_CYCLES);
  localparam logic [DELAY_W-1:0] HOLD_DATA_LAST = DELAY_W'(HOLD_DATA_CYCLES);
  localparam logic [DELAY_W-1:0] RELEASE_LAST   = DELAY_W'(RELEASE_WAIT_CYCLES);

  localparam ps2_pkg::count_t RX_LAST = ps2_pkg::count_t'(ps2_pkg::FRAME_BITS);
  localparam ps2_pkg::count_t TX_LAST = ps2_pkg::count_t'(ps2_pkg::FRAME_BITS - 1);

  ps2_pkg::link_state_t state, state_next;
  logic [DELAY_W-1:0]   delay, delay_next;
  logic                 err_next;

  ////////////////////
  // state registers
  ////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ps2_pkg::idle;
      delay <= '0;
      err   <= 1'b0;
    end else begin
      state <= state_next;
      delay <= delay_next;
      err   <= err_next;   // single-cycle pulse, default is 0
    end
  end

  // shifter commands straight from state
  assign busy  = (state != ps2_pkg::idle);
  assign clear = (state == ps2_pkg::idle);
  assign load  = (state == ps2_pkg::idle) && tx_valid;  // frame built while still idle
  assign shift = (state == ps2_pkg::rx_neg_edge) || (state == ps2_pkg::tx_clk_low);

  ////////////////////
  // next state
  ////////////////////
  always_comb begin
    state_next    = state;
    delay_next    = '0;      // counter only runs where a state asks for it
    err_next      = 1'b0;
    rx_done       = 1'b0;
    clk_low_next  = 1'b0;    // lines released unless a state pulls them
    data_low_next = 1'b0;
    case (state)
      ps2_pkg::idle: begin
        if (tx_valid) state_next = ps2_pkg::tx_force_clk_low;  // client wins
        else if (!clk_s) state_next = ps2_pkg::rx_neg_edge;    // device started a frame
      end

      // receive: sample on every falling device clock
      ps2_pkg::rx_neg_edge: state_next = ps2_pkg::rx_clk_low;  // shift happens here
      ps2_pkg::rx_clk_low: begin
        if (clk_s) state_next = ps2_pkg::rx_clk_high;
      end
      ps2_pkg::rx_clk_high: begin
        // last bit ends the frame without waiting for the clock
        if (bit_count == RX_LAST) begin
          state_next = ps2_pkg::idle;
          if (parity_ok) rx_done  = 1'b1;
          else           err_next = 1'b1;
        end else if (!clk_s) begin
          state_next = ps2_pkg::rx_neg_edge;
        end
      end

      // request to send
      ps2_pkg::tx_force_clk_low: begin
        clk_low_next = 1'b1;
        if (delay == HOLD_CLK_LAST) state_next = ps2_pkg::tx_bring_data_low;
        else delay_next = delay + DELAY_W'(1);
      end
      ps2_pkg::tx_bring_data_low: begin
        clk_low_next  = 1'b1;
        data_low_next = 1'b1;    // start bit, read by the device at clock release
        if (delay == HOLD_DATA_LAST) state_next = ps2_pkg::tx_release_clk;
        else delay_next = delay + DELAY_W'(1);
      end
      ps2_pkg::tx_release_clk: begin
        data_low_next = 1'b1;
        state_next    = ps2_pkg::tx_wait_first_neg_edge;
      end
      ps2_pkg::tx_wait_first_neg_edge: begin
        // released clock needs time to rise through the filter
        data_low_next = 1'b1;
        if (delay != RELEASE_LAST) begin
          delay_next = delay + DELAY_W'(1);
        end else if (!clk_s) begin
          state_next = ps2_pkg::tx_clk_low;
        end else begin
          delay_next = delay;    // park until the device clocks
        end
      end

      // data bits, device reads on the rising clock
      ps2_pkg::tx_clk_low: begin
        data_low_next = ~tx_bit;
        state_next    = ps2_pkg::tx_wait_pos_edge;
      end
      ps2_pkg::tx_wait_pos_edge: begin
        data_low_next = ~tx_bit;
        if (bit_count == TX_LAST) begin
          data_low_next = 1'b0;  // release, stop bit reads as 1
          state_next    = ps2_pkg::tx_wait_pos_edge_before_ack;
        end else if (clk_s) begin
          state_next = ps2_pkg::tx_clk_high;
        end
      end
      ps2_pkg::tx_clk_high: begin
        data_low_next = ~tx_bit;
        if (!clk_s) state_next = ps2_pkg::tx_clk_low;
      end

      // acknowledge
      ps2_pkg::tx_wait_pos_edge_before_ack: begin
        if (clk_s) state_next = ps2_pkg::tx_wait_ack;
      end
      ps2_pkg::tx_wait_ack: begin
        if (!clk_s) begin
          state_next = data_s ? ps2_pkg::tx_error_no_ack  // data left high
                              : ps2_pkg::tx_received_ack;
        end
      end
      ps2_pkg::tx_received_ack: begin
        if (clk_s) state_next = ps2_pkg::idle;
      end
      ps2_pkg::tx_error_no_ack: begin
        if (clk_s) begin
          err_next   = 1'b1;
          state_next = ps2_pkg::idle;
        end
      end

      default: begin             // stray encoding, recover
        err_next   = 1'b1;
        state_next = ps2_pkg::idle;
      end
    endcase
  end

endmodule

// File: logic/ps2_pkg.sv
package ps2_pkg;

  ////////////////////
  // frame geometry
  ////////////////////
  localparam int DATA_W     = 8;   // data bits per frame
  localparam int FRAME_BITS = 11;  // start + data + parity + stop

  typedef logic [DATA_W-1:0]     byte_t;
  typedef logic [FRAME_BITS-1:0] frame_t;
  typedef logic [3:0]            count_t;  // holds 0..FRAME_BITS

  ////////////////////
  // link states
  ////////////////////
  typedef enum logic [3:0] {
    idle,
    rx_neg_edge, rx_clk_low, rx_clk_high,                 // device to host
    tx_force_clk_low, tx_bring_data_low, tx_release_clk,  // request to send
    tx_wait_first_neg_edge,
    tx_clk_low, tx_wait_pos_edge, tx_clk_high,            // host to device bits
    tx_wait_pos_edge_before_ack, tx_wait_ack,             // device acknowledge
    tx_received_ack, tx_error_no_ack
  } link_state_t;

  // parity bit for a byte, such that ones in byte plus parity is odd
  function automatic logic odd_parity(input byte_t data);
    return ~^data;
  endfunction

endpackage

// File: run.sh
#!/bin/sh
# build the ps2_host testbench with verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module ps2_host_tb -o ps2_host_sim

out=$(./obj_dir/ps2_host_sim || true)
echo "$out"
echo "$out" | grep -q "^RESULT: PASS$"

// File: test/ps2_host_props.sv
`timescale 1ns/1ps

// protocol properties on the ps2_host client and pad ports
module ps2_host_props (
  input logic clk,
  input logic rst,
  input logic rx_valid,
  input logic err,
  input logic busy,
  input logic ps2_clk_low
);

  // received byte strobe lasts exactly one cycle
  rx_valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
    rx_valid |=> !rx_valid)
    else $error("rx_valid stayed high for a second cycle");

  // a frame ends either good or bad, never both
  no_rx_with_err: assert property (@(posedge clk) disable iff (rst)
    !(rx_valid && err))
    else $error("rx_valid and err high in the same cycle");

  // clock pull only happens inside a transmit request
  clk_pull_while_busy: assert property (@(posedge clk) disable iff (rst)
    ps2_clk_low |-> busy)
    else $error("ps2_clk_low asserted while the link is idle");

endmodule

bind ps2_host ps2_host_props u_props (
  .clk(clk), .rst(rst), .rx_valid(rx_valid), .err(err), .busy(busy),
  .ps2_clk_low(ps2_clk_low)
);

// File: test/ps2_host_tb.sv
`timescale 1ns/1ps

module ps2_host_tb;

  localparam int DEB        = 3;
  localparam int HOLD_CLK   = 40;
  localparam int HOLD_DATA  = 8;
  localparam int REL_WAIT   = 10;
  localparam int PHASE      = 20;    // device clock half period in system cycles
  localparam int WAIT_LIMIT = 2000;  // cycles before any wait gives up

  logic           clk, rst, tx_valid;
  ps2_pkg::byte_t tx_data, rx_data;
  logic           rx_valid, busy, err, ps2_clk_low, ps2_data_low;
  logic           dev_clk, dev_data;        // device pulls where 0 pulls the line low
  logic           ps2_clk_in, ps2_data_in;  // resolved bus levels
  logic [31:0]    lfsr;
  int             errors, timeouts;
  int             rx_total, err_total, req_total;   // monitor counts
  int             rx_start, err_start, req_start;   // snapshot per test
  ps2_pkg::byte_t d, prev;

  // open-drain wired-and of device and host
  assign ps2_clk_in  = dev_clk & ~ps2_clk_low;
  assign ps2_data_in = dev_data & ~ps2_data_low;

  ps2_host #(
    .DEBOUNCE_CYCLES(DEB), .HOLD_CLK_CYCLES(HOLD_CLK),
    .HOLD_DATA_CYCLES(HOLD_DATA), .RELEASE_WAIT_CYCLES(REL_WAIT)
  ) UUT (
    .clk(clk), .rst(rst), .ps2_clk_in(ps2_clk_in), .ps2_data_in(ps2_data_in),
    .tx_valid(tx_valid), .tx_data(tx_data), .rx_data(rx_data), .rx_valid(rx_valid),
    .busy(busy), .err(err), .ps2_clk_low(ps2_clk_low), .ps2_data_low(ps2_data_low)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // strobes counted mid-cycle away from the edges
  always @(negedge clk) begin
    if (!rst) begin
      if (rx_valid) rx_total++;
      if (err) err_total++;
      if (ps2_clk_low) req_total++;
    end
  end

  ////////////////////
  // helpers
  ////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32,22,2,1
  endfunction

  task automatic random_byte(output ps2_pkg::byte_t b);
    for (int i = 0; i < ps2_pkg::DATA_W; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      b[i] = lfsr[0];
    end
  endtask

  // parity bit giving an odd number of ones over byte plus parity
  function automatic logic parity_bit(input ps2_pkg::byte_t b);
    int ones;
    ones = 0;
    for (int i = 0; i < ps2_pkg::DATA_W; i++) begin
      if (b[i]) ones++;
    end
    return (ones % 2 == 0);
  endfunction

  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #5;  // inputs move just after the edge
  endtask

  task automatic check_byte(input string name, input ps2_pkg::byte_t got, exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input ps2_pkg::count_t got, exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout: %s", what);
  endtask

  task automatic snapshot();
    rx_start  = rx_total;
    err_start = err_total;
    req_start = req_total;
  endtask

  task automatic check_pulses(input ps2_pkg::count_t exp_rx, exp_err);
    check_count("rx_valid pulses", ps2_pkg::count_t'(rx_total - rx_start), exp_rx);
    check_count("err pulses", ps2_pkg::count_t'(err_total - err_start), exp_err);
  endtask

  task automatic wait_until_idle(input string what);
    int n;
    n = 0;
    while (busy && n < WAIT_LIMIT) begin
      step(1);
      n++;
    end
    if (busy) report_timeout(what);
    step(3);  // let the closing strobe land
  endtask

  ////////////////////
  // device model
  ////////////////////
  // one device bit that the host samples on the falling clock
  task automatic device_bit(input logic b);
    dev_data = b;
    step(PHASE / 2);
    dev_clk = 1'b0;
    step(PHASE);
    dev_clk = 1'b1;
    step(PHASE / 2);
  endtask

  task automatic send_frame(input ps2_pkg::byte_t b, input logic bad_parity);
    ps2_pkg::frame_t f;
    f = {1'b1, parity_bit(b) ^ bad_parity, b, 1'b0};  // stop, parity, data, start
    for (int i = 0; i < ps2_pkg::FRAME_BITS; i++) begin
      if (i == 5) check_flag("busy", busy, 1'b1);  // mid frame
      device_bit(f[i]);
    end
  endtask

  // device side of a host-to-device transfer
  task automatic device_receive(input ps2_pkg::byte_t b, input logic ack);
    int n;
    int low_cycles;
    logic [9:0] got;  // bits read on rising clocks
    n = 0;
    while (ps2_clk_in && n < WAIT_LIMIT) begin
      step(1);
      n++;
    end
    if (ps2_clk_in) begin
      report_timeout("host never pulled the clock low");
      return;
    end
    low_cycles = 0;
    while (!ps2_clk_in && low_cycles < WAIT_LIMIT) begin
      step(1);
      low_cycles++;
    end
    if (!ps2_clk_in) begin
      report_timeout("host never released the clock");
      return;
    end
    if (low_cycles < HOLD_CLK) begin
      errors++;
      $display("request to send held the clock low for only %0d cycles", low_cycles);
    end
    check_flag("ps2_data_in at clock release", ps2_data_in, 1'b0);  // start bit
    step(PHASE);
    for (int i = 0; i < 10; i++) begin
      dev_clk = 1'b0;
      step(PHASE);
      got[i]  = ps2_data_in;  // read as the clock rises
      dev_clk = 1'b1;
      step(PHASE);
    end
    check_byte("tx data bits", got[7:0], b);
    check_flag("tx parity bit", got[8], parity_bit(b));
    check_flag("tx stop bit", got[9], 1'b1);
    // acknowledge clock with data pulled low only when acking
    dev_data = ~ack;
    step(PHASE / 2);
    dev_clk = 1'b0;
    step(PHASE);
    dev_clk = 1'b1;
    step(PHASE / 2);
    dev_data = 1'b1;
  endtask

  task automatic request_send(input ps2_pkg::byte_t b);
    tx_data  = b;
    tx_valid = 1'b1;
    step(1);
    tx_valid = 1'b0;
  endtask

  ////////////////////
  // sequence
  ////////////////////
  initial begin
    rst      = 1'b1;
    tx_valid = 1'b0;
    tx_data  = '0;
    dev_clk  = 1'b1;  // device releases both lines
    dev_data = 1'b1;
    lfsr     = 32'h0215f0e0;
    errors   = 0;
    timeouts = 0;
    repeat (16) @(posedge clk);
    #5;
    rst = 1'b0;
    step(2);

    check_flag("rx_valid", rx_valid, 1'b0);
    check_flag("err", err, 1'b0);
    check_flag("busy", busy, 1'b0);
    check_flag("ps2_clk_low", ps2_clk_low, 1'b0);
    check_flag("ps2_data_low", ps2_data_low, 1'b0);

    for (int k = 0; k < 20; k++) begin  // good frames
      random_byte(d);
      snapshot();
      send_frame(d, 1'b0);
      wait_until_idle("reception did not end");
      check_pulses(4'd1, 4'd0);
      check_byte("rx_data", rx_data, d);
      prev = d;
    end

    for (int k = 0; k < 4; k++) begin   // inverted parity
      random_byte(d);
      snapshot();
      send_frame(d, 1'b1);
      wait_until_idle("bad parity reception did not end");
      check_pulses(4'd0, 4'd1);
      check_byte("rx_data", rx_data, prev);  // old byte kept
    end

    for (int k = 0; k < 4; k++) begin   // transmit with device ack
      random_byte(d);
      snapshot();
      request_send(d);
      device_receive(d, 1'b1);
      wait_until_idle("transmit with ack did not end");
      check_pulses(4'd0, 4'd0);
    end

    for (int k = 0; k < 2; k++) begin   // transmit without ack
      random_byte(d);
      snapshot();
      request_send(d);
      device_receive(d, 1'b0);
      wait_until_idle("transmit without ack did not end");
      check_pulses(4'd0, 4'd1);
    end

    random_byte(d);                     // tx_valid during a reception
    snapshot();
    fork
      send_frame(d, 1'b0);
      begin
        step(5 * PHASE);
        request_send(~d);
      end
    join
    wait_until_idle("reception with ignored tx_valid did not end");
    check_pulses(4'd1, 4'd0);
    check_byte("rx_data", rx_data, d);
    check_flag("ps2_clk_low", (req_total != req_start), 1'b0);

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
